/* filelist.f */
src/scope_pkg.sv
src/scope_regs.sv
src/scope_ctrl.sv
src/adc_spi_rx.sv
src/sample_packer.sv
src/mc_scope_top.sv
verification/adc_spi_model.sv
verification/scope_tb.sv

/* Bender.yml */
package:
  name: mc_scope

sources:
  # rtl, compile order
  - src/scope_pkg.sv
  - src/scope_regs.sv
  - src/scope_ctrl.sv
  - src/adc_spi_rx.sv
  - src/sample_packer.sv
  - src/mc_scope_top.sv
  # testbench
  - target: test
    files:
      - verification/adc_spi_model.sv
      - verification/scope_tb.sv

/* verification/scope_tb.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// scope testbench
// random adc codes, axi4-lite access, stream checked against a model
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module scope_tb
    import scope_pkg::*;
();

    localparam int clk_period = 4;
    localparam int max_div = 8;
    localparam int path_frames = 20;
    localparam int path_period = 120;
    localparam int div_rounds = 6;
    localparam int div_frames = 3;
    localparam int div_period = 300;
    localparam int bp_frames = 20;
    localparam int bp_period = 150;
    localparam int ovr_period = 20;
    localparam int ovr_stall = 600;
    localparam int dis_frames = 4;
    localparam int dis_period = 100;
    // frames x (32 x max divider + period + 50) per test plus margin
    localparam int timeout_cycles =
        path_frames * (32 * max_div + path_period + 50) +
        div_rounds * div_frames * (32 * max_div + div_period + 50) +
        bp_frames * (32 * max_div + bp_period + 50) +
        2 * (32 * max_div + ovr_period + 50) + ovr_stall +
        dis_frames * (32 * max_div + dis_period + 50) + 4 * dis_period + 5000;

    logic ss;
    logic rst;
    logic [addr_w-1:0] awaddr;
    logic awvalid;
    logic awready;
    logic [data_w-1:0] wdata;
    logic [data_w/8-1:0] wstrb;
    logic wvalid;
    logic wready;
    logic [1:0] bresp;
    logic bvalid;
    logic bready;
    logic [addr_w-1:0] araddr;
    logic arvalid;
    logic arready;
    logic [data_w-1:0] rdata;
    logic [1:0] rresp;
    logic rvalid;
    logic rready;
    logic cs_n;
    logic sclk;
    wire [n_channels-1:0] miso;
    stream_word_t m_tdata;
    logic m_tvalid;
    logic m_tready;

    int seed = 43262;
    sample_t next_code [n_channels];
    wire [31:0] conv_cnt [n_channels];
    stream_word_t exp_q [$];
    string test_name = "reset";
    int errors = 0;
    int err_base = 0;
    int n_pass = 0;
    int n_fail = 0;
    int cycles = 0;
    // 0 low, 1 high, 2 random per cycle
    int ready_mode = 1;
    logic stall_prev = 1'b0;
    stream_word_t held_word;
    longint wr_time;

    mc_scope_top UUT (
        .ss(ss), .rst(rst),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
        .bresp(bresp), .bvalid(bvalid), .bready(bready),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
        .cs_n(cs_n), .sclk(sclk), .miso(miso),
        .m_tdata(m_tdata), .m_tvalid(m_tvalid), .m_tready(m_tready)
    );

    // one adc per channel on the shared cs_n and sclk
    for (genvar g = 0; g < n_channels; g++) begin : g_adc
        adc_spi_model u_adc (
            .cs_n(cs_n), .sclk(sclk), .code(next_code[g]),
            .miso(miso[g]), .conv_count(conv_cnt[g])
        );
    end

    initial ss = 1'b0;
    always #2 ss = ~ss;

    always @(posedge ss) begin
        cycles = cycles + 1;
        if (cycles >= timeout_cycles) begin
            $display("timeout: run hung after %0d cycles in test %s", cycles, test_name);
            $display("TEST FAIL");
            $finish;
        end
    end

    // expected words carry the tag in 18:16 and the code in 13:0
    always @(negedge cs_n) begin
        for (int i = 0; i < n_channels; i++) begin
            exp_q.push_back(stream_word_t'((32'(i) << 16) | 32'(next_code[i])));
        end
    end

    // fresh codes once a conversion is over
    always @(posedge cs_n) begin
        for (int i = 0; i < n_channels; i++) begin
            next_code[i] = sample_t'($random(seed));
        end
    end

    always @(negedge ss) begin
        case (ready_mode)
            0: m_tready = 1'b0;
            1: m_tready = 1'b1;
            default: m_tready = $random(seed) & 1;
        endcase
    end

    task automatic check_word(input string name, input stream_word_t exp,
                              input stream_word_t act);
        if (act !== exp) begin
            $display("Mismatch %s: expected 0x%08h actual 0x%08h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_data(input string name, input logic [data_w-1:0] exp,
                              input logic [data_w-1:0] act);
        if (act !== exp) begin
            $display("Mismatch %s: expected 0x%08h actual 0x%08h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_resp(input string name, input logic [1:0] exp,
                              input logic [1:0] act);
        if (act !== exp) begin
            $display("Mismatch %s: expected %0d actual %0d", name, exp, act);
            errors++;
        end
    endtask

    // stream monitor sampling pre-edge values
    always @(posedge ss) begin
        if (!rst) begin
            // stalled word must still be there and unchanged
            if (stall_prev) begin
                if (!m_tvalid) begin
                    $display("%s: m_tvalid dropped before the stalled word was taken",
                             test_name);
                    errors++;
                end
                check_word({test_name, " stall"}, held_word, m_tdata);
            end
            if (m_tvalid && m_tready) begin
                if (exp_q.size() == 0) begin
                    $display("%s: stream word 0x%08h arrived with none expected",
                             test_name, m_tdata);
                    errors++;
                end else begin
                    check_word(test_name, exp_q.pop_front(), m_tdata);
                end
            end
            stall_prev = m_tvalid && !m_tready;
            held_word = m_tdata;
        end
    end

    // aw and w offered together and held until taken
    task automatic axi_write(input logic [addr_w-1:0] addr, input logic [data_w-1:0] data,
                             output logic [1:0] resp);
        @(negedge ss);
        awaddr = addr;
        wdata = data;
        wstrb = '1;
        awvalid = 1'b1;
        wvalid = 1'b1;
        @(posedge ss);
        while (!awready) @(posedge ss);
        wr_time = $time;
        if (!wready) begin
            $display("%s: write data not accepted together with its address", test_name);
            errors++;
        end
        @(negedge ss);
        awvalid = 1'b0;
        wvalid = 1'b0;
        bready = 1'b1;
        @(posedge ss);
        while (!bvalid) @(posedge ss);
        resp = bresp;
        @(negedge ss);
        bready = 1'b0;
    endtask

    task automatic axi_read(input logic [addr_w-1:0] addr, output logic [data_w-1:0] data,
                            output logic [1:0] resp);
        @(negedge ss);
        araddr = addr;
        arvalid = 1'b1;
        @(posedge ss);
        while (!arready) @(posedge ss);
        @(negedge ss);
        arvalid = 1'b0;
        rready = 1'b1;
        @(posedge ss);
        while (!rvalid) @(posedge ss);
        data = rdata;
        resp = rresp;
        @(negedge ss);
        rready = 1'b0;
    endtask

    task automatic reg_write(input logic [addr_w-1:0] addr, input logic [data_w-1:0] data);
        logic [1:0] resp;
        axi_write(addr, data, resp);
        check_resp({test_name, " write resp"}, resp_okay, resp);
    endtask

    task automatic reg_read(input logic [addr_w-1:0] addr, output logic [data_w-1:0] data);
        logic [1:0] resp;
        axi_read(addr, data, resp);
        check_resp({test_name, " read resp"}, resp_okay, resp);
    endtask

    task automatic expect_reg(input string name, input logic [addr_w-1:0] addr,
                              input logic [data_w-1:0] exp);
        logic [data_w-1:0] rd;
        reg_read(addr, rd);
        check_data(name, exp, rd);
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        err_base = errors;
    endtask

    task automatic end_test();
        if (errors == err_base) begin
            $display("test %s: ok", test_name);
            n_pass++;
        end else begin
            $display("test %s: failed with %0d errors", test_name, errors - err_base);
            n_fail++;
        end
    endtask

    // wait for the last conversion and all its words
    task automatic drain();
        repeat (4) @(negedge ss);
        while (exp_q.size() != 0 || !cs_n) @(negedge ss);
    endtask

    task automatic run_frames(input int div, input int per, input int frames);
        int base;
        reg_write(reg_clkdiv, div);
        reg_write(reg_period, per);
        base = conv_cnt[0];
        reg_write(reg_ctrl, 1);
        while (conv_cnt[0] - base < frames) @(negedge ss);
        reg_write(reg_ctrl, 0);
        drain();
    endtask

    // first sclk high and low phase of the next conversion
    task automatic measure_sclk(input int div);
        longint t_rise;
        longint t_fall;
        longint t_next;
        @(negedge cs_n);
        @(posedge sclk);
        t_rise = $time;
        @(negedge sclk);
        t_fall = $time;
        @(posedge sclk);
        t_next = $time;
        check_data("divider sclk high", div, (t_fall - t_rise) / clk_period);
        check_data("divider sclk low", div, (t_next - t_fall) / clk_period);
    endtask

    task automatic test_registers();
        logic [data_w-1:0] val;
        logic [data_w-1:0] rd;
        logic [addr_w-1:0] bad;
        logic [1:0] resp;
        begin_test("registers");
        expect_reg("registers ctrl reset", reg_ctrl, '0);
        expect_reg("registers period reset", reg_period, '0);
        expect_reg("registers clkdiv reset", reg_clkdiv, '0);
        expect_reg("registers overrun reset", reg_overrun, '0);
        val = $random(seed);
        reg_write(reg_period, val);
        expect_reg("registers period", reg_period, val);
        val = $random(seed) & 32'hff;
        reg_write(reg_clkdiv, val);
        expect_reg("registers clkdiv", reg_clkdiv, val);
        // odd offsets sit outside the map
        bad = addr_w'($random(seed)) | 4'h1;
        axi_write(bad, $random(seed), resp);
        check_resp("registers unmapped write", resp_slverr, resp);
        axi_read(bad, rd, resp);
        check_resp("registers unmapped read", resp_slverr, resp);
        // status only so the write is accepted and dropped
        reg_write(reg_overrun, $random(seed));
        expect_reg("registers overrun write", reg_overrun, '0);
        end_test();
    endtask

    task automatic test_divider();
        int div;
        begin_test("divider");
        ready_mode = 1;
        for (int r = 0; r < div_rounds; r++) begin
            div = ($random(seed) & 7) + 1;
            fork
                run_frames(div, div_period, div_frames);
                measure_sclk(div);
            join
        end
        end_test();
    endtask

    task automatic test_overrun();
        logic [data_w-1:0] ovr_base;
        logic [data_w-1:0] ovr;
        int conv_base;
        int enabled;
        longint t_on;
        begin_test("overrun");
        reg_read(reg_overrun, ovr_base);
        reg_write(reg_clkdiv, 1);
        reg_write(reg_period, ovr_period);
        ready_mode = 0;
        conv_base = conv_cnt[0];
        reg_write(reg_ctrl, 1);
        t_on = wr_time;
        repeat (ovr_stall) @(negedge ss);
        reg_write(reg_ctrl, 0);
        // enable high at each edge after the enabling write up to the disabling one
        enabled = (wr_time - t_on) / clk_period;
        ready_mode = 1;
        drain();
        // every tick either started a conversion or was an overrun
        reg_read(reg_overrun, ovr);
        check_data("overrun ticks", enabled / (ovr_period + 1),
                   (ovr - ovr_base) + (conv_cnt[0] - conv_base));
        end_test();
    endtask

    task automatic test_disable();
        int conv_base;
        begin_test("disable");
        ready_mode = 1;
        run_frames(2, dis_period, dis_frames);
        conv_base = conv_cnt[0];
        // several trigger periods with enable low
        repeat (4 * (dis_period + 1)) @(negedge ss);
        check_data("disable conversions", conv_base, conv_cnt[0]);
        end_test();
    endtask

    initial begin
        rst = 1'b1;
        awaddr = '0;
        awvalid = 1'b0;
        wdata = '0;
        wstrb = '0;
        wvalid = 1'b0;
        bready = 1'b0;
        araddr = '0;
        arvalid = 1'b0;
        rready = 1'b0;
        m_tready = 1'b1;
        for (int i = 0; i < n_channels; i++) begin
            next_code[i] = sample_t'($random(seed));
        end
        repeat (8) @(negedge ss);
        rst = 1'b0;

        test_registers();
        begin_test("sample path");
        ready_mode = 1;
        run_frames(2, path_period, path_frames);
        end_test();
        test_divider();
        // long period so random stalls never cause an overrun
        begin_test("backpressure");
        ready_mode = 2;
        run_frames(1, bp_period, bp_frames);
        ready_mode = 1;
        expect_reg("backpressure no overrun", reg_overrun, '0);
        end_test();
        test_overrun();
        test_disable();

        $display("tests passed %0d failed %0d", n_pass, n_fail);
        if (n_fail == 0 && errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

/* verification/adc_spi_model.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// serial adc model
// one 14-bit code per conversion, two zeros first
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module adc_spi_model
    import scope_pkg::*;
(
    input  logic    cs_n,
    input  logic    sclk,
    input  sample_t code,
    output logic    miso,
    output int      conv_count
);

    logic [frame_bits-1:0] word;
    int                    rises;

    initial begin
        miso = 1'b0;
        conv_count = 0;
        rises = 0;
        word = '0;
    end

    // new conversion, first bit out with cs_n
    always @(negedge cs_n) begin
        word = {2'b00, code};
        rises = 0;
        conv_count = conv_count + 1;
        miso = word[frame_bits-1];
    end

    always @(posedge sclk) begin
        if (!cs_n) begin
            rises = rises + 1;
        end
    end

    // next bit on the falling edge, held through the rising edge
    always @(negedge sclk) begin
        if (!cs_n && rises > 0 && rises < frame_bits) begin
            miso = word[frame_bits-1-rises];
        end
    end

endmodule

/* src/mc_scope_top.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// motor control scope top
// register slave, control, adc receiver, packer
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module mc_scope_top
    import scope_pkg::*;
(
    input  logic                  ss,
    input  logic                  rst,
    // axi4-lite slave
    input  logic [addr_w-1:0]     awaddr,
    input  logic                  awvalid,
    output logic                  awready,
    input  logic [data_w-1:0]     wdata,
    input  logic [data_w/8-1:0]   wstrb,
    input  logic                  wvalid,
    output logic                  wready,
    output logic [1:0]            bresp,
    output logic                  bvalid,
    input  logic                  bready,
    input  logic [addr_w-1:0]     araddr,
    input  logic                  arvalid,
    output logic                  arready,
    output logic [data_w-1:0]     rdata,
    output logic [1:0]            rresp,
    output logic                  rvalid,
    input  logic                  rready,
    // adc bus
    output logic                  cs_n,
    output logic                  sclk,
    input  logic [n_channels-1:0] miso,
    // sample stream
    output stream_word_t          m_tdata,
    output logic                  m_tvalid,
    input  logic                  m_tready
);

    logic                     enable;
    logic [data_w-1:0]        period;
    logic [clkdiv_w-1:0]      clkdiv;
    logic [data_w-1:0]        overrun_count;
    logic                     conv_start;
    logic                     conv_done;
    logic                     frame_load;
    logic                     frame_busy;
    sample_t [n_channels-1:0] samples;

    scope_regs u_regs (
        .ss(ss), .rst(rst),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
        .bresp(bresp), .bvalid(bvalid), .bready(bready),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
        .overrun_count(overrun_count),
        .enable(enable), .period(period), .clkdiv(clkdiv)
    );

    scope_ctrl u_ctrl (
        .ss(ss), .rst(rst),
        .enable(enable), .period(period),
        .conv_done(conv_done), .frame_busy(frame_busy),
        .conv_start(conv_start), .frame_load(frame_load),
        .overrun_count(overrun_count)
    );

    adc_spi_rx u_spi (
        .ss(ss), .rst(rst),
        .conv_start(conv_start), .clkdiv(clkdiv), .miso(miso),
        .cs_n(cs_n), .sclk(sclk),
        .conv_done(conv_done), .samples(samples)
    );

    sample_packer u_packer (
        .ss(ss), .rst(rst),
        .frame_load(frame_load), .samples(samples),
        .m_tready(m_tready), .m_tdata(m_tdata), .m_tvalid(m_tvalid),
        .frame_busy(frame_busy)
    );

endmodule

/* src/sample_packer.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// sample packer
// frame of six samples out as tagged stream words
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module sample_packer
    import scope_pkg::*;
(
    input  logic                     ss,
    input  logic                     rst,
    input  logic                     frame_load,
    input  sample_t [n_channels-1:0] samples,
    input  logic                     m_tready,
    output stream_word_t             m_tdata,
    output logic                     m_tvalid,
    output logic                     frame_busy
);

    sample_t [n_channels-1:0] frame;
    chan_t                    chan;
    logic                     last_chan;

    assign last_chan = (chan == chan_t'(n_channels - 1));

    // frame snapshot
    always_ff @(posedge ss) begin
        if (frame_load) begin
            frame <= samples;
        end
    end

    always_ff @(posedge ss) begin
        if (rst) begin
            m_tvalid <= 1'b0;
            chan <= '0;
        end else if (frame_load) begin
            m_tvalid <= 1'b1;
            chan <= '0;
        end else if (m_tvalid && m_tready) begin
            // advance only on accepted word
            if (last_chan) begin
                m_tvalid <= 1'b0;
                chan <= '0;
            end else begin
                chan <= chan + 1'b1;
            end
        end
    end

    // word built from held state, steady while stalled
    always_comb begin
        m_tdata = '0;
        m_tdata.chan = chan;
        m_tdata.sample = frame[chan];
    end

    // busy until the sixth handshake
    assign frame_busy = m_tvalid;

endmodule

/* src/adc_spi_rx.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// adc serial receiver
// drives cs_n and sclk, shifts six data lanes at once
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module adc_spi_rx
    import scope_pkg::*;
(
    input  logic                           ss,
    input  logic                           rst,
    input  logic                           conv_start,
    input  logic [clkdiv_w-1:0]            clkdiv,
    input  logic [n_channels-1:0]          miso,
    output logic                           cs_n,
    output logic                           sclk,
    output logic                           conv_done,
    output sample_t [n_channels-1:0]       samples
);

    logic                  active;
    logic [clkdiv_w-1:0]   half;
    logic [clkdiv_w-1:0]   half_cnt;
    logic [edge_w-1:0]     edges;
    logic [frame_bits-1:0] lane [n_channels];

    always_ff @(posedge ss) begin
        if (rst) begin
            active <= 1'b0;
            cs_n <= 1'b1;
            sclk <= 1'b1;
            conv_done <= 1'b0;
            half <= 8'd1;
            half_cnt <= '0;
            edges <= '0;
        end else begin
            conv_done <= 1'b0;
            if (!active) begin
                if (conv_start) begin
                    // sclk falls with cs_n, first bit due now
                    active <= 1'b1;
                    cs_n <= 1'b0;
                    sclk <= 1'b0;
                    half_cnt <= '0;
                    edges <= '0;
                    // divider latched per conversion, zero treated as one
                    half <= (clkdiv == '0) ? 8'd1 : clkdiv;
                end
            end else if (half_cnt == half - 1'b1) begin
                half_cnt <= '0;
                if (!sclk) begin
                    sclk <= 1'b1;
                    edges <= edges + 1'b1;
                end else if (edges == frame_bits[edge_w-1:0]) begin
                    // last high phase done, close the frame
                    active <= 1'b0;
                    cs_n <= 1'b1;
                    conv_done <= 1'b1;
                end else begin
                    sclk <= 1'b0;
                end
            end else begin
                half_cnt <= half_cnt + 1'b1;
            end
        end
    end

    // capture on the cycle sclk goes high
    always_ff @(posedge ss) begin
        if (active && !sclk && half_cnt == half - 1'b1) begin
            for (int i = 0; i < n_channels; i++) begin
                lane[i] <= {lane[i][frame_bits-2:0], miso[i]};
            end
        end
    end

    // leading zeros fall off the top
    always_comb begin
        for (int i = 0; i < n_channels; i++) begin
            samples[i] = lane[i][sample_w-1:0];
        end
    end

endmodule

/* src/scope_ctrl.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// scope control
// trigger timer, conversion sequencing, overrun count
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module scope_ctrl
    import scope_pkg::*;
(
    input  logic              ss,
    input  logic              rst,
    input  logic              enable,
    input  logic [data_w-1:0] period,
    input  logic              conv_done,
    input  logic              frame_busy,
    output logic              conv_start,
    output logic              frame_load,
    output logic [data_w-1:0] overrun_count
);

    logic [data_w-1:0] tick_cnt;
    logic              tick;
    ctrl_state_t       state;

    // one tick every period+1 cycles while enabled
    // >= guards against period shrinking mid count
    always_ff @(posedge ss) begin
        if (rst || !enable || period == '0) begin
            tick_cnt <= '0;
            tick <= 1'b0;
        end else if (tick_cnt >= period) begin
            tick_cnt <= '0;
            tick <= 1'b1;
        end else begin
            tick_cnt <= tick_cnt + 1'b1;
            tick <= 1'b0;
        end
    end

    always_ff @(posedge ss) begin
        if (rst) begin
            state <= idle;
            conv_start <= 1'b0;
            frame_load <= 1'b0;
            overrun_count <= '0;
        end else begin
            // single cycle strobes
            conv_start <= 1'b0;
            frame_load <= 1'b0;

            // tick outside wait_tick means a frame is still in flight
            if (tick && state != wait_tick && overrun_count != '1) begin
                overrun_count <= overrun_count + 1'b1;
            end

            case (state)
                idle: begin
                    if (enable) begin
                        state <= wait_tick;
                    end
                end
                wait_tick: begin
                    if (!enable) begin
                        state <= idle;
                    end else if (tick) begin
                        conv_start <= 1'b1;
                        state <= convert;
                    end
                end
                convert: begin
                    // packer still draining the previous frame
                    if (conv_done) begin
                        if (!frame_busy) begin
                            frame_load <= 1'b1;
                            state <= wait_tick;
                        end else begin
                            state <= hand_off;
                        end
                    end
                end
                hand_off: begin
                    if (!frame_busy) begin
                        frame_load <= 1'b1;
                        state <= wait_tick;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

endmodule

/* src/scope_regs.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// scope register slave
// axi4-lite access to enable, period, divider, overrun count
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module scope_regs
    import scope_pkg::*;
(
    input  logic                  ss,
    input  logic                  rst,
    // write address and data
    input  logic [addr_w-1:0]     awaddr,
    input  logic                  awvalid,
    output logic                  awready,
    input  logic [data_w-1:0]     wdata,
    input  logic [data_w/8-1:0]   wstrb,
    input  logic                  wvalid,
    output logic                  wready,
    // write response
    output logic [1:0]            bresp,
    output logic                  bvalid,
    input  logic                  bready,
    // read channels
    input  logic [addr_w-1:0]     araddr,
    input  logic                  arvalid,
    output logic                  arready,
    output logic [data_w-1:0]     rdata,
    output logic [1:0]            rresp,
    output logic                  rvalid,
    input  logic                  rready,
    // status in, settings out
    input  logic [data_w-1:0]     overrun_count,
    output logic                  enable,
    output logic [data_w-1:0]     period,
    output logic [clkdiv_w-1:0]   clkdiv
);

    logic wr_fire;
    logic rd_fire;
    logic wr_mapped;

    // byte lane merge for strobed writes
    function automatic logic [data_w-1:0] apply_strb(
        input logic [data_w-1:0]   cur,
        input logic [data_w-1:0]   data,
        input logic [data_w/8-1:0] strb
    );
        logic [data_w-1:0] res;
        res = cur;
        for (int b = 0; b < data_w / 8; b++) begin
            if (strb[b]) begin
                res[8*b +: 8] = data[8*b +: 8];
            end
        end
        return res;
    endfunction

    // aw and w taken together, one response outstanding
    assign awready = awvalid && wvalid && !bvalid;
    assign wready = awready;
    assign wr_fire = awvalid && awready && wvalid && wready;

    // single read in flight
    assign arready = !rvalid;
    assign rd_fire = arvalid && arready;

    // overrun offset is mapped but read only
    assign wr_mapped = (awaddr == reg_ctrl) || (awaddr == reg_period) ||
                       (awaddr == reg_clkdiv) || (awaddr == reg_overrun);

    always_ff @(posedge ss) begin
        if (rst) begin
            enable <= 1'b0;
            period <= '0;
            clkdiv <= '0;
            bvalid <= 1'b0;
        end else begin
            // response held until bready
            if (bvalid && bready) begin
                bvalid <= 1'b0;
            end
            if (wr_fire) begin
                bvalid <= 1'b1;
                case (awaddr)
                    reg_ctrl: begin
                        if (wstrb[0]) begin
                            enable <= wdata[0];
                        end
                    end
                    reg_period: period <= apply_strb(period, wdata, wstrb);
                    reg_clkdiv: begin
                        // divider fits the low byte
                        if (wstrb[0]) begin
                            clkdiv <= wdata[clkdiv_w-1:0];
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge ss) begin
        if (wr_fire) begin
            bresp <= wr_mapped ? resp_okay : resp_slverr;
        end
    end

    always_ff @(posedge ss) begin
        if (rst) begin
            rvalid <= 1'b0;
        end else if (rd_fire) begin
            rvalid <= 1'b1;
        end else if (rready) begin
            rvalid <= 1'b0;
        end
    end

    // read data captured at the ar handshake
    always_ff @(posedge ss) begin
        if (rd_fire) begin
            rresp <= resp_okay;
            case (araddr)
                reg_ctrl: rdata <= {{(data_w-1){1'b0}}, enable};
                reg_period: rdata <= period;
                reg_clkdiv: rdata <= {{(data_w-clkdiv_w){1'b0}}, clkdiv};
                reg_overrun: rdata <= overrun_count;
                default: begin
                    rdata <= '0;
                    rresp <= resp_slverr;
                end
            endcase
        end
    end

endmodule

/* src/scope_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// scope package
// widths, register map, sample and stream types, control states
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package scope_pkg;

    // adc front end
    localparam int n_channels = 6;
    localparam int sample_w = 14;
    // two leading zeros then 14 data bits, msb first
    localparam int frame_bits = 16;
    localparam int chan_w = 3;
    // counts sclk rising edges 0..frame_bits
    localparam int edge_w = $clog2(frame_bits + 1);

    // register bus
    localparam int data_w = 32;
    localparam int addr_w = 4;
    localparam int clkdiv_w = 8;

    // register byte offsets
    localparam logic [addr_w-1:0] reg_ctrl = 4'h0;
    localparam logic [addr_w-1:0] reg_period = 4'h4;
    localparam logic [addr_w-1:0] reg_clkdiv = 4'h8;
    localparam logic [addr_w-1:0] reg_overrun = 4'hc;

    // axi response codes
    localparam logic [1:0] resp_okay = 2'b00;
    localparam logic [1:0] resp_slverr = 2'b10;

    typedef logic [sample_w-1:0] sample_t;
    typedef logic [chan_w-1:0] chan_t;

    // tag in 18:16, sample in 13:0, rest zero
    typedef struct packed {
        logic [12:0] pad_hi;
        chan_t       chan;
        logic [1:0]  pad_lo;
        sample_t     sample;
    } stream_word_t;

    // conversion sequencing
    typedef enum logic [1:0] {
        idle,
        wait_tick,
        convert,
        hand_off
    } ctrl_state_t;

endpackage
